// ==== verilog/mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Reset PC, start of the code segment
`define CODE_SEG_PC     32'h0000_3000

// Fixed register indices
`define REG_ADDR_FLAG   5'd30
`define REG_ADDR_RET    5'd31

// Instruction memory depth in words
`define IMEM_WORDS      256

`endif

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

        typedef enum logic [5:0] {
                OP_SPECIAL = 6'h00,
                OP_J       = 6'h02,
                OP_JAL     = 6'h03,
                OP_BEQ     = 6'h04,
                OP_ADDI    = 6'h08,
                OP_ADDIU   = 6'h09,
                OP_ORI     = 6'h0d,
                OP_LUI     = 6'h0f,
                OP_LW      = 6'h23,
                OP_SW      = 6'h2b
        } opE;

        // Funct codes under OP_SPECIAL
        typedef enum logic [5:0] {
                F_SLL  = 6'h00,
                F_JR   = 6'h08,
                F_ADDU = 6'h21,
                F_SUBU = 6'h23,
                F_SLT  = 6'h2a
        } functE;

        typedef struct packed {
                opE          op;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [4:0]  rd;
                logic [4:0]  shamt;
                functE       funct;
        } rInstrT;

        typedef struct packed {
                opE          op;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [15:0] imm;
        } iInstrT;

        typedef struct packed {
                opE          op;
                logic [25:0] target;
        } jInstrT;

        // One instruction word seen through its three formats
        typedef union packed {
                rInstrT r;
                iInstrT i;
                jInstrT j;
        } instrT;

        typedef enum logic [3:0] {
                K_NOP, K_ADDU, K_SUBU, K_SLT, K_JR, K_ORI, K_LUI, K_ADDI,
                K_ADDIU, K_LW, K_SW, K_BEQ, K_J, K_JAL, K_ILLEGAL
        } instrKindE;

endpackage

// ==== verilog/core_pkg.sv ====
package core_pkg;

        typedef enum logic [2:0] {S1, S2, S3, S4, S5} stateE;

        typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_OR, ALU_SLT, ALU_LUI} aluOpE;

        typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pcSelE;

        typedef enum logic [1:0] {DST_RD, DST_RT, DST_RET, DST_FLAG} regDstE;

        typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSelE;

        typedef struct packed {
                logic   pcWe;
                pcSelE  pcSel;
                logic   irWe;
                logic   regWe;
                regDstE regDst;
                wbSelE  wbSel;
                aluOpE  aluOp;
                logic   aluSrcImm;
                logic   extSigned;
                logic   memReq;
                logic   memWe;
        } ctrlT;

        // One record per completed instruction
        typedef struct packed {
                logic [31:0] pc;
                logic [31:0] nextPc;
                logic        regWe;
                logic [4:0]  regAddr;
                logic [31:0] regData;
        } retireT;

        typedef struct packed {
                logic        cyc;
                logic        stb;
                logic        we;
                logic [31:0] adr;
                logic [31:0] datW;
                logic [3:0]  sel;
        } wbMasterT;

        typedef struct packed {
                logic        ack;
                logic [31:0] datR;
        } wbSlaveT;

endpackage

// ==== verilog/ifu.sv ====
`timescale 1ns/1ps
`include "mips_settings.svh"

module ifu
        import isa_pkg::*;
        import core_pkg::*;
(
        input  logic                           clk,
        input  logic                           rst,
        input  ctrlT                           ctrl,
        input  logic                           progWe,
        input  logic [$clog2(`IMEM_WORDS)-1:0] progAddr,
        input  logic [31:0]                    progData,
        input  logic [31:0]                    rsData,
        output logic [31:0]                    pc,
        output logic [31:0]                    pcPlus4,
        output logic [31:0]                    nextPc,
        output instrT                          instr
);
        localparam int AW = $clog2(`IMEM_WORDS);

        logic [31:0] imem [`IMEM_WORDS];
        logic [31:0] pcOff;
        logic [31:0] branchOff;

        // Word index relative to the code segment
        assign pcOff = pc - `CODE_SEG_PC;
        assign pcPlus4 = pc + 32'd4;
        assign branchOff = {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};

        always_comb begin
                case (ctrl.pcSel)
                PC_BRANCH: nextPc = pcPlus4 + branchOff;
                PC_JUMP:   nextPc = {pcPlus4[31:28], instr.j.target, 2'b00};
                PC_REG:    nextPc = rsData;
                default:   nextPc = pcPlus4;
                endcase
        end

        always_ff @(posedge clk) begin
                if (progWe) begin
                        imem[progAddr] <= progData;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        pc <= `CODE_SEG_PC;
                        instr <= '0;
                end else begin
                        if (ctrl.irWe) begin
                                instr <= imem[pcOff[AW+1:2]];
                        end
                        if (ctrl.pcWe) begin
                                pc <= nextPc;
                        end
                end
        end

        // Only a jr to an unaligned rs can break this
        pcAligned: assert property (@(posedge clk) disable iff (rst)
                pc[1:0] == 2'b00);

endmodule

// ==== verilog/gpr.sv ====
`timescale 1ns/1ps

module gpr (
        input  logic        clk,
        input  logic        rst,
        input  logic [4:0]  rs,
        input  logic [4:0]  rt,
        input  logic        we,
        input  logic [4:0]  wAddr,
        input  logic [31:0] wData,
        output logic [31:0] rsData,
        output logic [31:0] rtData
);
        logic [31:0] regs [32];

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we && wAddr != 5'd0) begin
                        // $zero is never written
                        regs[wAddr] <= wData;
                end
        end

        assign rsData = regs[rs];
        assign rtData = regs[rt];

        // Destination comes from the decoder mux in the top level
        wAddrKnown: assert property (@(posedge clk) disable iff (rst)
                we |-> !$isunknown(wAddr));

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu
        import core_pkg::*;
(
        input  aluOpE       op,
        input  logic [31:0] a,
        input  logic [31:0] b,
        output logic [31:0] y,
        output logic        zero,
        output logic        overflow
);
        logic [31:0] sum;
        logic [31:0] diff;

        assign sum = a + b;
        assign diff = a - b;

        always_comb begin
                case (op)
                ALU_SUB: y = diff;
                ALU_OR:  y = a | b;
                ALU_SLT: y = {31'd0, $signed(a) < $signed(b)};
                ALU_LUI: y = {b[15:0], 16'h0000};
                default: y = sum;
                endcase
        end

        assign zero = (y == 32'd0);

        // Signed overflow of add, operands alike and sum sign flipped
        assign overflow = (op == ALU_ADD) && (a[31] == b[31]) && (sum[31] != a[31]);

endmodule

// ==== verilog/ctr.sv ====
`timescale 1ns/1ps

module ctr
        import isa_pkg::*;
        import core_pkg::*;
(
        input  logic  clk,
        input  logic  rst,
        input  instrT instr,
        input  logic  zero,
        input  logic  overflow,
        input  logic  memDone,
        output ctrlT  ctrl,
        output stateE state,
        output logic  retireValid
);
        instrKindE kind;
        stateE     nextState;
        logic      taken;
        logic      ovf;

        // Decode
        always_comb begin
                kind = K_ILLEGAL;
                case (instr.r.op)
                OP_SPECIAL: begin
                        case (instr.r.funct)
                        F_ADDU: kind = K_ADDU;
                        F_SUBU: kind = K_SUBU;
                        F_SLT:  kind = K_SLT;
                        F_JR:   kind = K_JR;
                        F_SLL:  kind = (instr.j.target == 26'd0) ? K_NOP : K_ILLEGAL;
                        default: kind = K_ILLEGAL;
                        endcase
                end
                OP_J:     kind = K_J;
                OP_JAL:   kind = K_JAL;
                OP_BEQ:   kind = K_BEQ;
                OP_ADDI:  kind = K_ADDI;
                OP_ADDIU: kind = K_ADDIU;
                OP_ORI:   kind = K_ORI;
                OP_LUI:   kind = K_LUI;
                OP_LW:    kind = K_LW;
                OP_SW:    kind = K_SW;
                default:  kind = K_ILLEGAL;
                endcase
        end

        always_comb begin
                case (state)
                S1: nextState = S2;
                S2: nextState = S3;
                S3: nextState = (kind == K_LW || kind == K_SW) ? S4 : S5;
                S4: nextState = memDone ? S5 : S4;
                default: nextState = S1;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= S1;
                end else begin
                        state <= nextState;
                end
        end

        // ALU flags kept for writeback
        always_ff @(posedge clk) begin
                if (state == S3) begin
                        taken <= zero;
                        ovf <= overflow;
                end
        end

        always_comb begin
                ctrl = '0;
                ctrl.aluOp = ALU_ADD;
                ctrl.extSigned = 1'b1;
                case (kind)
                K_SUBU, K_BEQ: ctrl.aluOp = ALU_SUB;
                K_SLT:         ctrl.aluOp = ALU_SLT;
                K_ORI: begin
                        ctrl.aluOp = ALU_OR;
                        ctrl.aluSrcImm = 1'b1;
                        ctrl.extSigned = 1'b0;
                end
                K_LUI: begin
                        ctrl.aluOp = ALU_LUI;
                        ctrl.aluSrcImm = 1'b1;
                end
                K_ADDI, K_ADDIU, K_LW, K_SW: ctrl.aluSrcImm = 1'b1;
                default: ;
                endcase

                ctrl.irWe = (state == S1);

                if (state == S4) begin
                        ctrl.memReq = 1'b1;
                        ctrl.memWe = (kind == K_SW);
                end

                if (state == S5) begin
                        ctrl.pcWe = 1'b1;
                        case (kind)
                        K_ADDU, K_SUBU, K_SLT: ctrl.regWe = 1'b1;
                        K_ORI, K_LUI, K_ADDIU: begin
                                ctrl.regWe = 1'b1;
                                ctrl.regDst = DST_RT;
                        end
                        K_ADDI: begin
                                // Overflow goes to the flag register instead of rt
                                ctrl.regWe = 1'b1;
                                ctrl.regDst = ovf ? DST_FLAG : DST_RT;
                        end
                        K_LW: begin
                                ctrl.regWe = 1'b1;
                                ctrl.regDst = DST_RT;
                                ctrl.wbSel = WB_MEM;
                        end
                        K_BEQ: ctrl.pcSel = taken ? PC_BRANCH : PC_SEQ;
                        K_J:   ctrl.pcSel = PC_JUMP;
                        K_JAL: begin
                                ctrl.pcSel = PC_JUMP;
                                ctrl.regWe = 1'b1;
                                ctrl.regDst = DST_RET;
                                ctrl.wbSel = WB_PC4;
                        end
                        K_JR:  ctrl.pcSel = PC_REG;
                        default: ;
                        endcase
                end
        end

        assign retireValid = (state == S5);

        memReqInS4: assert property (@(posedge clk) disable iff (rst)
                ctrl.memReq |-> state == S4);

endmodule

// ==== verilog/lsu.sv ====
`timescale 1ns/1ps

module lsu
        import core_pkg::*;
(
        input  logic        clk,
        input  logic        rst,
        input  ctrlT        ctrl,
        input  logic [31:0] addr,
        input  logic [31:0] storeData,
        output wbMasterT    wbOut,
        input  wbSlaveT     wbIn,
        output logic [31:0] loadData,
        output logic        done
);
        // Request lasts exactly as long as S4, so the bus drops after ack
        always_comb begin
                wbOut.cyc = ctrl.memReq;
                wbOut.stb = ctrl.memReq;
                wbOut.we = ctrl.memReq & ctrl.memWe;
                wbOut.adr = {addr[31:2], 2'b00};
                wbOut.datW = storeData;
                // Word accesses only
                wbOut.sel = 4'hf;
        end

        assign done = wbOut.cyc & wbIn.ack;

        always_ff @(posedge clk) begin
                if (done && !wbOut.we) begin
                        loadData <= wbIn.datR;
                end
        end

        stbNeedsCyc: assert property (@(posedge clk) disable iff (rst)
                $rose(wbOut.stb) |-> wbOut.cyc);

        // Address, data and direction steady across wait states
        busStable: assert property (@(posedge clk) disable iff (rst)
                wbOut.stb && !wbIn.ack |=> wbOut.stb && $stable(wbOut.adr)
                        && $stable(wbOut.we) && $stable(wbOut.datW));

endmodule

// ==== verilog/mips.sv ====
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips
        import isa_pkg::*;
        import core_pkg::*;
(
        input  logic                           clk,
        input  logic                           rst,
        input  logic                           progWe,
        input  logic [$clog2(`IMEM_WORDS)-1:0] progAddr,
        input  logic [31:0]                    progData,
        output wbMasterT                       wbOut,
        input  wbSlaveT                        wbIn,
        output logic                           retireValid,
        output retireT                         retire
);
        ctrlT        ctrl;
        stateE       state;
        instrT       instr;
        logic [31:0] pc;
        logic [31:0] pcPlus4;
        logic [31:0] nextPc;
        logic [31:0] rsData;
        logic [31:0] rtData;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] ext;
        logic [31:0] aluB;
        logic [31:0] aluY;
        logic [31:0] aluOut;
        logic [31:0] loadData;
        logic [31:0] wData;
        logic [4:0]  wAddr;
        logic        zero;
        logic        overflow;
        logic        memDone;

        ifu ifu (
                .clk(clk), .rst(rst), .ctrl(ctrl),
                .progWe(progWe), .progAddr(progAddr), .progData(progData),
                .rsData(opA), .pc(pc), .pcPlus4(pcPlus4), .nextPc(nextPc), .instr(instr)
        );

        gpr gpr (
                .clk(clk), .rst(rst), .rs(instr.r.rs), .rt(instr.r.rt),
                .we(ctrl.regWe), .wAddr(wAddr), .wData(wData),
                .rsData(rsData), .rtData(rtData)
        );

        assign ext = ctrl.extSigned ? {{16{instr.i.imm[15]}}, instr.i.imm}
                                    : {16'h0000, instr.i.imm};
        assign aluB = ctrl.aluSrcImm ? ext : opB;

        alu alu (
                .op(ctrl.aluOp), .a(opA), .b(aluB),
                .y(aluY), .zero(zero), .overflow(overflow)
        );

        ctr ctr (
                .clk(clk), .rst(rst), .instr(instr), .zero(zero), .overflow(overflow),
                .memDone(memDone), .ctrl(ctrl), .state(state), .retireValid(retireValid)
        );

        lsu lsu (
                .clk(clk), .rst(rst), .ctrl(ctrl), .addr(aluOut), .storeData(opB),
                .wbOut(wbOut), .wbIn(wbIn), .loadData(loadData), .done(memDone)
        );

        // Operands in S2, ALU result in S3
        always_ff @(posedge clk) begin
                if (state == S2) begin
                        opA <= rsData;
                        opB <= rtData;
                end
                if (state == S3) begin
                        aluOut <= aluY;
                end
        end

        always_comb begin
                case (ctrl.regDst)
                DST_RT:   wAddr = instr.r.rt;
                DST_RET:  wAddr = `REG_ADDR_RET;
                DST_FLAG: wAddr = `REG_ADDR_FLAG;
                default:  wAddr = instr.r.rd;
                endcase
        end

        always_comb begin
                case (ctrl.wbSel)
                WB_MEM:  wData = loadData;
                WB_PC4:  wData = pcPlus4;
                default: wData = aluOut;
                endcase
                // addi overflow sets the flag
                if (ctrl.regDst == DST_FLAG) begin
                        wData = 32'd1;
                end
        end

        always_comb begin
                retire.pc = pc;
                retire.nextPc = nextPc;
                retire.regWe = ctrl.regWe;
                retire.regAddr = wAddr;
                retire.regData = wData;
        end

endmodule

// ==== bench/mips_tb.sv ====
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_tb
        import isa_pkg::*;
        import core_pkg::*;
();
        localparam int AW = $clog2(`IMEM_WORDS);
        localparam int MAX_WAIT = 3;
        // Upper bound on program words over all tests
        localparam int TOTAL_WORDS = 40;
        localparam int TIMEOUT_NS = 2 * TOTAL_WORDS * (5 + MAX_WAIT) * 4 + 1000;

        logic          clk;
        logic          rst;
        logic          progWe;
        logic [AW-1:0] progAddr;
        logic [31:0]   progData;
        wbMasterT      wbOut;
        wbSlaveT       wbIn = '0;
        logic          retireValid;
        retireT        retire;

        logic [31:0] dmem [64];
        logic [31:0] writeCount;
        logic [31:0] fullSelCount;
        logic [31:0] lastWrAdr;
        logic [31:0] lastWrDat;
        int          waitLeft;

        logic [31:0] prog [$];
        retireT      expected [$];

        mips UUT (
                .clk(clk), .rst(rst),
                .progWe(progWe), .progAddr(progAddr), .progData(progData),
                .wbOut(wbOut), .wbIn(wbIn),
                .retireValid(retireValid), .retire(retire)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        function automatic logic [31:0] fillWord(logic [31:0] adr);
                return {adr[15:0], adr[31:16]} ^ 32'h5a5a_a5a5;
        endfunction

        // Wishbone slave with random wait states, one ack per request
        always @(negedge clk) begin
                if (rst) begin
                        wbIn <= '0;
                        waitLeft = -1;
                        writeCount <= '0;
                        fullSelCount <= '0;
                        for (int i = 0; i < 64; i++) begin
                                dmem[i] <= fillWord(32'(i * 4));
                        end
                end else if (wbIn.ack || !(wbOut.cyc && wbOut.stb)) begin
                        wbIn.ack <= 1'b0;
                        waitLeft = -1;
                end else begin
                        if (waitLeft < 0) begin
                                waitLeft = int'($urandom % (MAX_WAIT + 1));
                        end
                        if (waitLeft == 0) begin
                                wbIn.ack <= 1'b1;
                                if (wbOut.sel === 4'hf) begin
                                        fullSelCount <= fullSelCount + 32'd1;
                                end
                                if (wbOut.we) begin
                                        dmem[wbOut.adr[7:2]] <= wbOut.datW;
                                        writeCount <= writeCount + 32'd1;
                                        lastWrAdr <= wbOut.adr;
                                        lastWrDat <= wbOut.datW;
                                end else begin
                                        wbIn.datR <= dmem[wbOut.adr[7:2]];
                                end
                        end else begin
                                waitLeft = waitLeft - 1;
                        end
                end
        end

        function automatic logic [31:0] encR(int rs, int rt, int rd, functE f);
                return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, f};
        endfunction

        function automatic logic [31:0] encI(opE op, int rs, int rt, int imm);
                return {op, rs[4:0], rt[4:0], imm[15:0]};
        endfunction

        function automatic logic [31:0] encJ(opE op, logic [31:0] target);
                return {op, target[27:2]};
        endfunction

        // Byte address of program word idx
        function automatic logic [31:0] at(int idx);
                return `CODE_SEG_PC + 32'(idx * 4);
        endfunction

        function automatic void addExpected(int idx, logic [31:0] nextPc, logic we,
                                            int addr, logic [31:0] data);
                retireT r;
                r.pc = at(idx);
                r.nextPc = nextPc;
                r.regWe = we;
                r.regAddr = addr[4:0];
                r.regData = data;
                expected.push_back(r);
        endfunction

        function automatic void sequential(int idx, logic we, int addr, logic [31:0] data);
                addExpected(idx, at(idx + 1), we, addr, data);
        endfunction

        function automatic string formatRetire(retireT r);
                return $sformatf("pc=%h nextPc=%h regWe=%b r%0d=%h",
                                 r.pc, r.nextPc, r.regWe, r.regAddr, r.regData);
        endfunction

        task automatic abortRun();
                $display("Testbench failed");
                $fatal(1, "Stopped at first error");
        endtask

        task automatic checkRetire(string name, retireT exp, retireT act);
                logic bad;
                bad = exp.pc !== act.pc || exp.nextPc !== act.nextPc
                        || exp.regWe !== act.regWe;
                // Destination only matters when a register is written
                if (exp.regWe && (exp.regAddr !== act.regAddr
                                  || exp.regData !== act.regData)) begin
                        bad = 1'b1;
                end
                if (bad) begin
                        $display("CHECK FAILED %s: expected %s, actual %s",
                                 name, formatRetire(exp), formatRetire(act));
                        abortRun();
                end
        endtask

        task automatic checkWord(string name, logic [31:0] exp, logic [31:0] act);
                if (exp !== act) begin
                        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
                        abortRun();
                end
        endtask

        task automatic waitRetire();
                @(negedge clk);
                while (!retireValid) begin
                        @(negedge clk);
                end
        endtask

        // Load under reset, release, then check one retire per expected record
        task automatic runProgram(string name);
                rst = 1'b1;
                foreach (prog[i]) begin
                        @(negedge clk);
                        progWe = 1'b1;
                        progAddr = AW'(i);
                        progData = prog[i];
                end
                @(negedge clk);
                progWe = 1'b0;
                repeat (2) @(negedge clk);
                rst = 1'b0;
                foreach (expected[i]) begin
                        waitRetire();
                        checkRetire(name, expected[i], retire);
                end
                prog.delete();
                expected.delete();
        endtask

        task automatic aluOps();
                logic [31:0] r1;
                logic [31:0] r2;
                r1 = 32'h0000_1234;
                r2 = 32'h8000_0005;
                prog.push_back(encI(OP_ORI, 0, 1, 'h1234));
                prog.push_back(encI(OP_LUI, 0, 2, 'h8000));
                prog.push_back(encI(OP_ORI, 2, 2, 'h0005));
                prog.push_back(encR(1, 2, 3, F_ADDU));
                prog.push_back(encR(1, 2, 4, F_SUBU));
                prog.push_back(encR(2, 1, 5, F_SLT));
                prog.push_back(encR(1, 2, 6, F_SLT));
                sequential(0, 1'b1, 1, r1);
                sequential(1, 1'b1, 2, 32'h8000_0000);
                sequential(2, 1'b1, 2, r2);
                sequential(3, 1'b1, 3, r1 + r2);
                sequential(4, 1'b1, 4, r1 - r2);
                // Signed compare, r2 is negative
                sequential(5, 1'b1, 5, 32'd1);
                sequential(6, 1'b1, 6, 32'd0);
                runProgram("aluOps");
        endtask

        task automatic addiFlag();
                prog.push_back(encI(OP_LUI, 0, 1, 'h7fff));
                prog.push_back(encI(OP_ORI, 1, 1, 'hffff));
                prog.push_back(encI(OP_ADDI, 0, 2, 16));
                prog.push_back(encI(OP_ADDI, 0, 7, -1));
                prog.push_back(encI(OP_ADDI, 1, 3, 1));
                prog.push_back(encR(3, 0, 4, F_ADDU));
                prog.push_back(encI(OP_ADDIU, 1, 5, 1));
                prog.push_back(encR(`REG_ADDR_FLAG, 0, 6, F_ADDU));
                sequential(0, 1'b1, 1, 32'h7fff_0000);
                sequential(1, 1'b1, 1, 32'h7fff_ffff);
                sequential(2, 1'b1, 2, 32'd16);
                sequential(3, 1'b1, 7, 32'hffff_ffff);
                // 0x7fffffff + 1 overflows, flag set instead of rt
                sequential(4, 1'b1, `REG_ADDR_FLAG, 32'd1);
                sequential(5, 1'b1, 4, 32'd0);
                sequential(6, 1'b1, 5, 32'h8000_0000);
                sequential(7, 1'b1, 6, 32'd1);
                runProgram("addiFlag");
        endtask

        task automatic loadStore();
                logic [31:0] base;
                base = 32'h0000_0040;
                prog.push_back(encI(OP_ORI, 0, 1, 'h0040));
                prog.push_back(encI(OP_LUI, 0, 2, 'hcafe));
                prog.push_back(encI(OP_ORI, 2, 2, 'hbabe));
                prog.push_back(encI(OP_SW, 1, 2, 8));
                prog.push_back(encI(OP_LW, 1, 3, 8));
                prog.push_back(encI(OP_LW, 1, 4, -4));
                sequential(0, 1'b1, 1, base);
                sequential(1, 1'b1, 2, 32'hcafe_0000);
                sequential(2, 1'b1, 2, 32'hcafe_babe);
                sequential(3, 1'b0, 0, 32'd0);
                sequential(4, 1'b1, 3, 32'hcafe_babe);
                sequential(5, 1'b1, 4, fillWord(base - 32'd4));
                runProgram("loadStore");
                checkWord("loadStore write count", 32'd1, writeCount);
                checkWord("loadStore write address", base + 32'd8, lastWrAdr);
                checkWord("loadStore write data", 32'hcafe_babe, lastWrDat);
                // One store and two loads, each with all byte lanes selected
                checkWord("loadStore full-word accesses", 32'd3, fullSelCount);
        endtask

        task automatic branchJump();
                prog.push_back(encI(OP_ORI, 0, 1, 1));
                prog.push_back(encI(OP_ORI, 0, 2, 1));
                prog.push_back(encI(OP_BEQ, 1, 2, 2));
                prog.push_back(encI(OP_ORI, 0, 9, 'hbad));
                prog.push_back(encI(OP_ORI, 0, 9, 'hbad));
                prog.push_back(encI(OP_BEQ, 1, 0, 5));
                prog.push_back(encJ(OP_JAL, at(9)));
                prog.push_back(encI(OP_ORI, 0, 9, 'hbad));
                prog.push_back(encI(OP_ORI, 0, 9, 'hbad));
                prog.push_back(encI(OP_ORI, 0, 4, at(12)));
                prog.push_back(encR(4, 0, 0, F_JR));
                prog.push_back(encI(OP_ORI, 0, 9, 'hbad));
                prog.push_back(encJ(OP_J, at(14)));
                prog.push_back(encI(OP_ORI, 0, 9, 'hbad));
                prog.push_back(encR(`REG_ADDR_RET, 0, 5, F_ADDU));
                sequential(0, 1'b1, 1, 32'd1);
                sequential(1, 1'b1, 2, 32'd1);
                // Taken, pc+4 plus offset of two words
                addExpected(2, at(3) + (32'd2 << 2), 1'b0, 0, 32'd0);
                addExpected(5, at(6), 1'b0, 0, 32'd0);
                addExpected(6, at(9), 1'b1, `REG_ADDR_RET, at(7));
                sequential(9, 1'b1, 4, at(12));
                addExpected(10, at(12), 1'b0, 0, 32'd0);
                addExpected(12, at(14), 1'b0, 0, 32'd0);
                sequential(14, 1'b1, 5, at(7));
                runProgram("branchJump");
        endtask

        task automatic resetNop();
                prog.push_back(32'h0000_0000);
                prog.push_back(32'hfc00_0000);
                prog.push_back(encI(OP_ORI, 0, 1, 7));
                sequential(0, 1'b0, 0, 32'd0);
                // Unknown opcode behaves like a nop
                sequential(1, 1'b0, 0, 32'd0);
                sequential(2, 1'b1, 1, 32'd7);
                runProgram("resetNop");
        endtask

        initial begin
                #(TIMEOUT_NS);
                $display("Timeout: the DUT did not retire the expected instructions in time");
                abortRun();
        end

        initial begin
                void'($urandom(87267));
                rst = 1'b1;
                progWe = 1'b0;
                progAddr = '0;
                progData = '0;
                aluOps();
                addiFlag();
                loadStore();
                branchJump();
                resetNop();
                $display("Testbench passed");
                $finish;
        end

endmodule

// ==== mips.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/ifu.sv
verilog/gpr.sv
verilog/alu.sv
verilog/ctr.sv
verilog/lsu.sv
verilog/mips.sv
bench/mips_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mips testbench with Verilator

LOG=sim.log

if ! verilator --binary --assert --top-module mips_tb -f mips.f; then
    echo "ERROR: Verilator compile failed"
    exit 1
fi

./obj_dir/Vmips_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "ERROR: simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
    echo "RESULT: PASS"
    exit 0
fi

echo "RESULT: FAIL"
exit 1
